// File: logic/muldiv_settings.svh
// Width and iteration constants for the M-extension multiply/divide block
// Included by the type package and by every RTL file that sizes a datapath
`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

// Operand and result width, RV64
`define MULDIV_XLEN 64

// Operation identifier carried to writeback
`define MULDIV_TAG_W 4

// One restoring step per quotient bit
`define MULDIV_DIV_STEPS `MULDIV_XLEN

`endif

// File: logic/muldiv_types_pkg.sv
// Datapath vector types and the issued-operation struct
// Referenced by scoped name from the RTL and the testbench
`include "muldiv_settings.svh"

package muldiv_types_pkg;

    // Full-width operand or result
    typedef logic [`MULDIV_XLEN-1:0] bus64_t;

    // Double-width product, before word selection
    typedef logic [2*`MULDIV_XLEN-1:0] bus128_t;

    typedef logic [31:0] bus32_t;              // Low word for the W forms

    typedef logic [2:0] funct3_t;              // Bit 2 splits multiply from divide

    typedef logic [`MULDIV_TAG_W-1:0] tag_t;   // Follows the op to writeback

    // One issued operation, about 136 bits
    typedef struct packed {
        funct3_t funct3;    // MUL..MULHU, DIV..REMU
        logic    int_32;    // W form, low word only
        bus64_t  rs1;       // Multiplicand or dividend
        bus64_t  rs2;       // Multiplier or divisor
        tag_t    tag;
    } muldiv_op_t;

endpackage

// File: logic/muldiv_ctrl_pkg.sv
// Divider FSM encoding and the writeback payload shared by both units
// Referenced by scoped name, builds on the datapath types
package muldiv_ctrl_pkg;

    // Divider sequence
    typedef enum logic [1:0] {
        DIV_IDLE,   // Waiting for a start
        DIV_RUN,    // Shift-subtract steps
        DIV_FIX,    // Signs, special cases, word select
        DIV_HOLD    // Result held until the bus is granted
    } div_state_t;

    // Result with its tag, 68 bits
    typedef struct packed {
        muldiv_types_pkg::tag_t   tag;
        muldiv_types_pkg::bus64_t result;
    } wb_t;

endpackage

// File: logic/mul_unit.sv
// Signed/unsigned 64x64 multiplier for MUL, MULH, MULHSU, MULHU and MULW
// Combinational core followed by a single result register
`timescale 1ns/100ps
`include "muldiv_settings.svh"

module mul_unit (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       valid_i,
    input  muldiv_types_pkg::muldiv_op_t op_i,
    output logic                       req_o,
    output muldiv_ctrl_pkg::wb_t       wb_o
);

    logic                      sign1;        // Operand signs, word or doubleword
    logic                      sign2;
    muldiv_types_pkg::bus64_t  rs1_abs;      // Conditioned operands
    muldiv_types_pkg::bus64_t  rs2_abs;
    logic                      neg_prod;     // Product must be negated
    muldiv_types_pkg::bus128_t prod;
    muldiv_types_pkg::bus128_t prod_signed;
    muldiv_types_pkg::bus32_t  low_word;
    muldiv_types_pkg::bus64_t  result;
    logic                      req_q;
    muldiv_ctrl_pkg::wb_t      wb_q;

    // MULW looks at bit 31, everything else at the top bit
    assign sign1 = op_i.int_32 ? op_i.rs1[31] : op_i.rs1[`MULDIV_XLEN-1];
    assign sign2 = op_i.int_32 ? op_i.rs2[31] : op_i.rs2[`MULDIV_XLEN-1];

    // Make operands positive per signed/unsigned pairing
    always_comb begin
        case (op_i.funct3)
            3'b000, 3'b001: begin                          // MUL/MULW, MULH
                rs1_abs  = sign1 ? -op_i.rs1 : op_i.rs1;
                rs2_abs  = sign2 ? -op_i.rs2 : op_i.rs2;
                neg_prod = sign1 ^ sign2;
            end
            3'b010: begin                                  // MULHSU, rs2 unsigned
                rs1_abs  = sign1 ? -op_i.rs1 : op_i.rs1;
                rs2_abs  = op_i.rs2;
                neg_prod = sign1;
            end
            default: begin                                 // MULHU
                rs1_abs  = op_i.rs1;
                rs2_abs  = op_i.rs2;
                neg_prod = 1'b0;
            end
        endcase
    end

    assign prod        = rs1_abs * rs2_abs;                // Unsigned 128-bit product
    assign prod_signed = neg_prod ? -prod : prod;          // Restore sign
    assign low_word    = prod_signed[31:0];

    // Low half for MUL, high half for the MULH family
    always_comb begin
        if (op_i.funct3 != 3'b000)
            result = prod_signed[2*`MULDIV_XLEN-1:`MULDIV_XLEN];
        else if (op_i.int_32)
            result = {{(`MULDIV_XLEN-32){low_word[31]}}, low_word};  // MULW
        else
            result = prod_signed[`MULDIV_XLEN-1:0];
    end

    always_ff @(posedge clk_i) begin
        if (reset_i)
            req_q <= 1'b0;
        else
            req_q <= valid_i;                              // One cycle to writeback
    end

    // Payload only loads on an accepted op
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            wb_q.tag    <= op_i.tag;
            wb_q.result <= result;
        end
    end

    assign req_o = req_q;
    assign wb_o  = wb_q;

endmodule

// File: logic/div_unit.sv
// Restoring shift-subtract divider for DIV, DIVU, REM, REMU and W forms
// One quotient bit per cycle, result held until the writeback grant
`timescale 1ns/100ps
`include "muldiv_settings.svh"

module div_unit (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       start_i,
    input  muldiv_types_pkg::muldiv_op_t op_i,
    input  logic                       grant_i,
    output logic                       busy_o,
    output logic                       req_o,
    output muldiv_ctrl_pkg::wb_t       wb_o
);

    localparam int CNT_W = $clog2(`MULDIV_DIV_STEPS + 1);

    muldiv_ctrl_pkg::div_state_t state_q;
    logic [CNT_W-1:0]            step_q;
    muldiv_types_pkg::bus64_t    quo_q;        // Dividend shifts out, quotient in
    muldiv_types_pkg::bus64_t    rem_q;        // Partial remainder
    muldiv_types_pkg::bus64_t    divisor_q;    // Divisor magnitude
    muldiv_types_pkg::bus64_t    dividend_q;   // Extended dividend for special cases
    logic                        q_neg_q;
    logic                        r_neg_q;
    logic                        dz_q;         // Divide by zero
    logic                        ovf_q;        // MIN / -1
    logic                        is_rem_q;
    logic                        w_q;
    muldiv_ctrl_pkg::wb_t        wb_q;
    logic                        is_signed;
    muldiv_types_pkg::bus32_t    a_lo;
    muldiv_types_pkg::bus32_t    b_lo;
    muldiv_types_pkg::bus64_t    a_ext;
    muldiv_types_pkg::bus64_t    b_ext;
    logic                        a_neg;
    logic                        b_neg;
    logic                        a_min;
    logic [`MULDIV_XLEN:0]       trial;        // Remainder with next dividend bit
    logic [`MULDIV_XLEN:0]       diff;
    logic                        fits;
    muldiv_types_pkg::bus64_t    q_fix;
    muldiv_types_pkg::bus64_t    r_fix;
    muldiv_types_pkg::bus64_t    res_fix;

    assign is_signed = ~op_i.funct3[0];        // DIV, REM
    assign a_lo      = op_i.rs1[31:0];
    assign b_lo      = op_i.rs2[31:0];

    // W forms extend the low word by signedness
    always_comb begin
        a_ext = op_i.rs1;
        b_ext = op_i.rs2;
        if (op_i.int_32) begin
            a_ext = {{(`MULDIV_XLEN-32){is_signed & a_lo[31]}}, a_lo};
            b_ext = {{(`MULDIV_XLEN-32){is_signed & b_lo[31]}}, b_lo};
        end
    end

    assign a_neg = is_signed & a_ext[`MULDIV_XLEN-1];
    assign b_neg = is_signed & b_ext[`MULDIV_XLEN-1];
    assign a_min = op_i.int_32 ? (a_lo == 32'h8000_0000)
                               : (a_ext == {1'b1, {(`MULDIV_XLEN-1){1'b0}}});

    // Restoring step
    assign trial = {rem_q, quo_q[`MULDIV_XLEN-1]};
    assign diff  = trial - {1'b0, divisor_q};
    assign fits  = trial >= {1'b0, divisor_q};

    // Signs, special cases and word select
    always_comb begin
        q_fix = q_neg_q ? -quo_q : quo_q;
        r_fix = r_neg_q ? -rem_q : rem_q;
        if (dz_q) begin
            q_fix = '1;
            r_fix = dividend_q;
        end else if (ovf_q) begin
            q_fix = dividend_q;
            r_fix = '0;
        end
        res_fix = is_rem_q ? r_fix : q_fix;
        if (w_q)
            res_fix = {{(`MULDIV_XLEN-32){res_fix[31]}}, res_fix[31:0]};
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= muldiv_ctrl_pkg::DIV_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                muldiv_ctrl_pkg::DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= muldiv_ctrl_pkg::DIV_RUN;
                        step_q  <= '0;
                    end
                end
                muldiv_ctrl_pkg::DIV_RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == CNT_W'(`MULDIV_DIV_STEPS - 1))
                        state_q <= muldiv_ctrl_pkg::DIV_FIX;     // Last bit done
                end
                muldiv_ctrl_pkg::DIV_FIX:  state_q <= muldiv_ctrl_pkg::DIV_HOLD;
                muldiv_ctrl_pkg::DIV_HOLD: begin
                    if (grant_i)
                        state_q <= muldiv_ctrl_pkg::DIV_IDLE;
                end
                default: state_q <= muldiv_ctrl_pkg::DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_q)
            muldiv_ctrl_pkg::DIV_IDLE: begin
                if (start_i) begin
                    quo_q      <= a_neg ? -a_ext : a_ext;        // Magnitudes
                    divisor_q  <= b_neg ? -b_ext : b_ext;
                    rem_q      <= '0;
                    dividend_q <= a_ext;
                    q_neg_q    <= a_neg ^ b_neg;
                    r_neg_q    <= a_neg;                         // Remainder follows dividend
                    dz_q       <= (b_ext == '0);
                    ovf_q      <= is_signed & a_min & (b_ext == '1);
                    is_rem_q   <= op_i.funct3[1];
                    w_q        <= op_i.int_32;
                    wb_q.tag   <= op_i.tag;
                end
            end
            muldiv_ctrl_pkg::DIV_RUN: begin
                quo_q <= {quo_q[`MULDIV_XLEN-2:0], fits};
                rem_q <= fits ? diff[`MULDIV_XLEN-1:0] : trial[`MULDIV_XLEN-1:0];
            end
            muldiv_ctrl_pkg::DIV_FIX: wb_q.result <= res_fix;
            default: ;                                            // Hold payload
        endcase
    end

    assign busy_o = (state_q != muldiv_ctrl_pkg::DIV_IDLE);
    assign req_o  = (state_q == muldiv_ctrl_pkg::DIV_HOLD);      // Stable until granted
    assign wb_o   = wb_q;

endmodule

// File: logic/wb_arbiter.sv
// Fixed-priority owner of the shared writeback bus
// Multiplier first since its stage cannot stall, divider waits in its hold state
`timescale 1ns/100ps

module wb_arbiter (
    input  logic                 mul_req_i,
    input  muldiv_ctrl_pkg::wb_t mul_wb_i,
    input  logic                 div_req_i,
    input  muldiv_ctrl_pkg::wb_t div_wb_i,
    output logic                 div_grant_o,
    output logic                 wb_valid_o,
    output muldiv_ctrl_pkg::wb_t wb_o
);

    logic mul_sel;      // Multiplier owns the bus this cycle
    logic div_sel;

    // Multiplier wins any conflict
    assign mul_sel = mul_req_i;
    assign div_sel = div_req_i & ~mul_req_i;

    // Divider sees its grant only when the bus is free of a product
    assign div_grant_o = div_sel;

    // One pulse per winning request
    assign wb_valid_o = mul_sel | div_sel;

    // Payload mux, tag travels with the result
    always_comb begin
        if (mul_sel)
            wb_o = mul_wb_i;
        else
            wb_o = div_wb_i;   // Don't care when nothing is valid
    end

endmodule

// File: logic/muldiv_top.sv
// M-extension execute stage, routes issued ops to the multiplier or divider
// Both results leave on one arbitrated writeback bus with their tags
`timescale 1ns/100ps

module muldiv_top (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         issue_valid_i,
    input  muldiv_types_pkg::muldiv_op_t issue_op_i,
    output logic                         div_busy_o,
    output logic                         wb_valid_o,
    output muldiv_ctrl_pkg::wb_t         wb_o
);

    logic                 mul_valid;    // funct3 0..3
    logic                 div_start;    // funct3 4..7
    logic                 mul_req;
    muldiv_ctrl_pkg::wb_t mul_wb;
    logic                 div_req;
    muldiv_ctrl_pkg::wb_t div_wb;
    logic                 div_grant;

    // funct3 bit 2 picks the unit
    assign mul_valid = issue_valid_i & ~issue_op_i.funct3[2];
    assign div_start = issue_valid_i &  issue_op_i.funct3[2];

    mul_unit u_mul (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (mul_valid),
        .op_i    (issue_op_i),
        .req_o   (mul_req),
        .wb_o    (mul_wb)
    );

    // Issuer keeps divides away while busy
    div_unit u_div (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .start_i (div_start),
        .op_i    (issue_op_i),
        .grant_i (div_grant),
        .busy_o  (div_busy_o),
        .req_o   (div_req),
        .wb_o    (div_wb)
    );

    wb_arbiter u_arb (
        .mul_req_i   (mul_req),
        .mul_wb_i    (mul_wb),
        .div_req_i   (div_req),
        .div_wb_i    (div_wb),
        .div_grant_o (div_grant),
        .wb_valid_o  (wb_valid_o),
        .wb_o        (wb_o)
    );

endmodule

// File: tb/muldiv_chk.sv
// Issue, hold and grant rules of the multiply/divide block
// Bound into the top level, sees the divider and arbiter wiring
`timescale 1ns/100ps

module muldiv_chk (
    input logic                 clk_i,
    input logic                 reset_i,
    input logic                 div_start_i,
    input logic                 div_busy_i,
    input logic                 div_req_i,
    input muldiv_ctrl_pkg::wb_t div_wb_i,
    input logic                 div_grant_i,
    input logic                 wb_valid_i
);

    // Divides only reach an idle divider
    no_start_busy: assert property (@(posedge clk_i) disable iff (reset_i)
        div_start_i |-> !div_busy_i) else $error("divide started while divider busy");

    // Held result must not move before its grant
    req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        div_req_i && !div_grant_i |=> div_req_i && $stable(div_wb_i))
        else $error("divider request or result changed before grant");

    quiet_reset: assert property (@(posedge clk_i)
        reset_i |=> !wb_valid_i) else $error("writeback valid during reset");

    // Divider drops its request right after the grant
    one_grant: assert property (@(posedge clk_i) disable iff (reset_i)
        div_grant_i |=> !div_req_i) else $error("divider granted twice for one result");

endmodule

bind muldiv_top muldiv_chk u_chk (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .div_start_i (div_start),
    .div_busy_i  (div_busy_o),
    .div_req_i   (div_req),
    .div_wb_i    (div_wb),
    .div_grant_i (div_grant),
    .wb_valid_i  (wb_valid_o)
);

// File: tb/muldiv_tb.sv
// Random and directed test of the multiply/divide block against a per-tag model
// Run from the project root through run.sh, the bound checker watches the bus rules
`timescale 1ns/100ps
`include "muldiv_settings.svh"

module muldiv_tb;

    localparam int          NTAGS      = 1 << `MULDIV_TAG_W;
    localparam int          WAIT_LIMIT = `MULDIV_DIV_STEPS + 20;
    localparam logic [63:0] MIN64      = 64'h8000_0000_0000_0000;
    localparam logic [63:0] WMIN       = 64'hffff_ffff_8000_0000;    // Word minimum

    logic                         clk_i = 1'b0;
    logic                         reset_i;
    logic                         issue_valid_i;
    muldiv_types_pkg::muldiv_op_t issue_op_i;
    logic                         div_busy_o;
    logic                         wb_valid_o;
    muldiv_ctrl_pkg::wb_t         wb_o;

    logic [31:0]              lfsr_q = 32'd73916;
    muldiv_types_pkg::bus64_t exp_res [NTAGS];     // Model result by tag
    logic                     pending [NTAGS];
    logic                     is_mul [NTAGS];
    int                       issue_cyc [NTAGS];
    logic                     div_out;             // A divide is in flight
    muldiv_types_pkg::tag_t   next_tag;
    int                       cyc = 0;
    int                       checks = 0;
    int                       errors = 0;
    int                       tests = 0;
    int                       bad_tests = 0;

    always #10 clk_i = ~clk_i;                     // 20 ns period
    always @(posedge clk_i) cyc <= cyc + 1;

    muldiv_top uut (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .issue_valid_i (issue_valid_i),
        .issue_op_i    (issue_op_i),
        .div_busy_o    (div_busy_o),
        .wb_valid_o    (wb_valid_o),
        .wb_o          (wb_o)
    );

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[62:0], fb};
        end
        return v;
    endfunction

    // Corner values come up in most draws
    function automatic muldiv_types_pkg::bus64_t rand_operand();
        case (rand_bits(3))
            0: return '0;
            1: return 64'd1;
            2: return '1;
            3: return MIN64;
            4: return WMIN;
            default: return rand_bits(64);
        endcase
    endfunction

    // Expected result straight from the M-extension rules
    function automatic muldiv_types_pkg::bus64_t model(input muldiv_types_pkg::muldiv_op_t op);
        logic [127:0]       a;
        logic [127:0]       b;
        logic [127:0]       p;
        logic               sgn;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        q;
        logic [63:0]        r;
        logic [63:0]        res;
        if (!op.funct3[2]) begin
            // Extend to 128 bits by operand signedness, product mod 2^128 is exact
            a = (op.funct3 == 3'b011) ? {64'd0, op.rs1} : {{64{op.rs1[63]}}, op.rs1};
            b = op.funct3[1] ? {64'd0, op.rs2} : {{64{op.rs2[63]}}, op.rs2};
            p = a * b;
            if (op.funct3 != 3'b000)
                return p[127:64];                  // MULH family
            return op.int_32 ? {{32{p[31]}}, p[31:0]} : p[63:0];
        end
        sgn = !op.funct3[0];                       // DIV, REM
        ua  = op.rs1;
        ub  = op.rs2;
        if (op.int_32) begin
            ua = {{32{sgn & op.rs1[31]}}, op.rs1[31:0]};
            ub = {{32{sgn & op.rs2[31]}}, op.rs2[31:0]};
        end
        sa = ua;
        sb = ub;
        if (ub == '0) begin
            q = '1;                                // Divide by zero
            r = ua;
        end else if (sgn && ua == MIN64 && ub == '1) begin
            q = ua;                                // Signed overflow
            r = '0;
        end else if (sgn) begin
            q = sa / sb;
            r = sa % sb;
        end else begin
            q = ua / ub;
            r = ua % ub;
        end
        res = op.funct3[1] ? r : q;
        return op.int_32 ? {{32{res[31]}}, res[31:0]} : res;
    endfunction

    function automatic logic any_pending();
        for (int i = 0; i < NTAGS; i++)
            if (pending[i])
                return 1'b1;
        return 1'b0;
    endfunction

    task automatic timeout(input string what);
        $display("Timeout at cycle %0d, %s", cyc, what);
        errors++;
    endtask

    // Falling edge, then check busy and whatever the bus carries
    task automatic next_cycle();
        muldiv_types_pkg::tag_t t;
        @(negedge clk_i);
        issue_valid_i = 1'b0;
        assert (div_busy_o == div_out) else begin
            $display("FAIL div_busy_o expected %h got %h at cycle %0d", div_out, div_busy_o, cyc);
            errors++;
        end
        if (wb_valid_o) begin
            t = wb_o.tag;
            checks++;
            assert (pending[t]) else begin
                $display("Writeback with tag %0d that has no operation pending", t);
                errors++;
            end
            assert (!pending[t] || wb_o.result == exp_res[t]) else begin
                $display("FAIL wb_o.result tag %0d expected %h got %h", t, exp_res[t], wb_o.result);
                errors++;
            end
            assert (!pending[t] || !is_mul[t] || cyc == issue_cyc[t] + 1) else begin
                $display("Multiply with tag %0d was not written back one cycle after issue", t);
                errors++;
            end
            if (pending[t] && !is_mul[t])
                div_out = 1'b0;
            pending[t] = 1'b0;
        end
    endtask

    task automatic wait_div_idle();
        int n;
        n = 0;
        while ((div_out || div_busy_o) && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (div_out || div_busy_o)
            timeout("divider never came back to idle");
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (any_pending() && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (any_pending())
            timeout("results still pending");
    endtask

    // Drive one op at the current falling edge, model it under a fresh tag
    task automatic issue(input muldiv_types_pkg::funct3_t f3, input logic w,
                         input muldiv_types_pkg::bus64_t a, input muldiv_types_pkg::bus64_t b);
        if (f3[2])
            wait_div_idle();
        for (int i = 0; i < NTAGS && pending[next_tag]; i++)
            next_tag++;                            // Skip tags still in flight
        issue_op_i.funct3 = f3;
        issue_op_i.int_32 = w;
        issue_op_i.rs1    = a;
        issue_op_i.rs2    = b;
        issue_op_i.tag    = next_tag;
        exp_res[next_tag]   = model(issue_op_i);
        pending[next_tag]   = 1'b1;
        is_mul[next_tag]    = !f3[2];
        issue_cyc[next_tag] = cyc;
        if (f3[2])
            div_out = 1'b1;
        issue_valid_i = 1'b1;
        next_tag++;
    endtask

    task automatic end_test(input string name, input int e0);
        tests++;
        if (errors != e0)
            bad_tests++;
        $display("%-32s %s", name, (errors == e0) ? "ok" : "ERRORS");
    endtask

    initial begin
        muldiv_types_pkg::funct3_t f3;
        int                        e0;
        reset_i       = 1'b1;
        issue_valid_i = 1'b0;
        issue_op_i    = '0;
        div_out       = 1'b0;
        next_tag      = '0;
        for (int i = 0; i < NTAGS; i++) begin
            pending[i] = 1'b0;
            is_mul[i]  = 1'b0;
        end
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        e0 = errors;
        repeat (6) next_cycle();                   // Nothing may appear on the bus
        end_test("idle after reset", e0);

        e0 = errors;
        for (int i = 0; i < 48; i++) begin
            next_cycle();
            f3 = muldiv_types_pkg::funct3_t'(rand_bits(2));
            issue(f3, (f3 == 3'b000) & rand_bits(1) != 0, rand_operand(), rand_operand());
        end
        drain();
        end_test("back-to-back multiplies", e0);

        e0 = errors;
        for (int i = 0; i < 16; i++) begin
            next_cycle();
            f3 = 3'b100 | muldiv_types_pkg::funct3_t'(rand_bits(2));
            issue(f3, rand_bits(1) != 0, rand_operand(), rand_operand());
        end
        drain();
        end_test("random divides", e0);

        e0 = errors;
        for (int w = 0; w < 2; w++) begin
            for (int f = 4; f < 8; f++) begin
                next_cycle();
                issue(muldiv_types_pkg::funct3_t'(f), w != 0, rand_bits(64), '0);
                next_cycle();
                issue(muldiv_types_pkg::funct3_t'(f), w != 0, (w != 0) ? WMIN : MIN64, '1);
            end
        end
        drain();
        end_test("divide by zero and overflow", e0);

        e0 = errors;
        next_cycle();
        issue(3'b100, 1'b0, rand_operand(), rand_bits(64));
        for (int i = 0; i < `MULDIV_DIV_STEPS + 10; i++) begin
            next_cycle();                          // Bus stays busy past the divide's end
            issue(muldiv_types_pkg::funct3_t'(rand_bits(2)), 1'b0, rand_operand(), rand_operand());
        end
        drain();
        end_test("divide behind multiply stream", e0);

        $display("tests %0d, tests with errors %0d, writebacks %0d, errors %0d",
                 tests, bad_tests, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: src.f
+incdir+logic
logic/muldiv_types_pkg.sv
logic/muldiv_ctrl_pkg.sv
logic/mul_unit.sv
logic/div_unit.sv
logic/wb_arbiter.sv
logic/muldiv_top.sv
tb/muldiv_chk.sv
tb/muldiv_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, status follows the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module muldiv_tb \
    -f src.f --Mdir obj_dir -o muldiv_sim

./obj_dir/muldiv_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^sim passed$" sim.log; then
    exit 0
fi
exit 1
